//--- rtl/lsu_pkg.sv
// LSU widths, outstanding depth, access size enum, request/bus/write-back structs
`default_nettype none

package lsu_pkg;

  ////////////////////////////// Widths
  localparam int ADDR_W = 32;                           // Byte address
  localparam int DATA_W = 32;                           // Bus and register data
  localparam int BE_W   = 4;                            // One enable per byte lane

  ////////////////////////////// Outstanding depth
  localparam int MAX_OUTSTANDING = 2;                   // Granted but unanswered transfers
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);   // Counts 0..MAX_OUTSTANDING
  localparam int PTR_W = $clog2(MAX_OUTSTANDING);       // Write-back queue pointer
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(MAX_OUTSTANDING);

  // Access size, same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // EX request, held stable until ready
  typedef struct packed {
    logic [ADDR_W-1:0] operand_a;                       // Base register
    logic [ADDR_W-1:0] operand_b;                       // Immediate offset
    logic [DATA_W-1:0] wdata;                           // Store data, register order
    lsu_size_e         size;
    logic              sext;                            // Sign extend loads
    logic              we;                              // 1 for store
  } lsu_req_t;

  // Data bus request payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;                           // Already rotated onto byte lanes
  } obi_req_t;

  // Write-back control, one per address phase
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;                                 // Low address bits of the access
    logic       last;                                   // Low only on first half of a split
  } wb_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/lsu_req_align.sv
// Address generation, split detection, split phase register, byte enables, store rotation
`timescale 1ns/1ps
`default_nettype none

module lsu_req_align (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              valid_i,     // EX access present
  input  wire lsu_pkg::lsu_req_t req_i,
  input  wire logic              advance_i,   // Current phase granted
  output lsu_pkg::obi_req_t      bus_o,
  output logic                   split_o,     // First phase of a two-phase access
  output lsu_pkg::wb_ctrl_t      wb_ctrl_o
);

  logic [lsu_pkg::ADDR_W-1:0] addr;           // Raw effective address
  logic [1:0]                 offset;
  logic                       needs_split;
  logic                       split_q;        // Second phase in progress
  logic [lsu_pkg::BE_W-1:0]   be;
  logic [2*lsu_pkg::DATA_W-1:0] wdata_dbl;

  assign addr   = req_i.operand_a + req_i.operand_b;
  assign offset = addr[1:0];

  // Word off alignment, or halfword crossing into the next word
  assign needs_split = ((req_i.size == lsu_pkg::SIZE_WORD) && (offset != 2'b00)) ||
                       ((req_i.size == lsu_pkg::SIZE_HALF) && (offset == 2'b11));

  assign split_o = valid_i && !split_q && needs_split;

  // Split phase register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      split_q <= 1'b0;                        // Nothing in EX, next access starts clean
    end else if (advance_i) begin
      split_q <= split_o;                     // Set after first half, cleared after second
    end
  end

  ////////////////////////////// Byte enables
  always_comb begin
    be = 4'b0000;
    case (req_i.size)
      lsu_pkg::SIZE_BYTE: be = 4'b0001 << offset;
      lsu_pkg::SIZE_HALF: begin
        if (split_q) be = 4'b0001;            // Upper byte lands in lane 0
        else         be = (offset == 2'b11) ? 4'b1000 : (4'b0011 << offset);
      end
      lsu_pkg::SIZE_WORD: begin
        if (split_q) be = 4'b1111 >> (3'd4 - {1'b0, offset});  // Low k lanes
        else         be = 4'b1111 << offset;
      end
      default: be = 4'b0000;
    endcase
  end

  // Rotate left by offset bytes, both halves of a split share it
  assign wdata_dbl = {req_i.wdata, req_i.wdata} << {offset, 3'b000};

  ////////////////////////////// Bus payload
  always_comb begin
    bus_o.addr  = split_q ? ({addr[lsu_pkg::ADDR_W-1:2], 2'b00} + lsu_pkg::ADDR_W'(4)) : addr;
    bus_o.we    = req_i.we;
    bus_o.be    = be;
    bus_o.wdata = wdata_dbl[2*lsu_pkg::DATA_W-1:lsu_pkg::DATA_W];
  end

  // Control travelling with this phase to the response side
  always_comb begin
    wb_ctrl_o.size   = req_i.size;
    wb_ctrl_o.sext   = req_i.sext;
    wb_ctrl_o.we     = req_i.we;
    wb_ctrl_o.offset = offset;                // Original offset, also for second half
    wb_ctrl_o.last   = !split_o;
  end

endmodule

`default_nettype wire

//--- rtl/lsu_outstanding_ctrl.sv
// Outstanding transfer counter, bus request gating, phase advance, EX ready, busy
`timescale 1ns/1ps
`default_nettype none

module lsu_outstanding_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic valid_i,        // EX access present
  input  wire logic split_i,        // Current phase is first half of a split
  input  wire logic bus_gnt_i,
  input  wire logic bus_rvalid_i,
  output logic      bus_req_o,
  output logic      ready_o,        // Access done with all address phases
  output logic      advance_o,      // Current phase accepted by the bus
  output logic      busy_o
);

  logic [lsu_pkg::CNT_W-1:0] cnt_q;       // Granted, not yet answered
  logic [lsu_pkg::CNT_W-1:0] cnt_next;
  logic                      cnt_full;
  logic                      count_up;
  logic                      count_down;

  ////////////////////////////// Request gating

  // No room for another transfer until a response frees a slot
  assign cnt_full = (cnt_q == lsu_pkg::CNT_FULL);

  // Request follows valid directly, no registered stage
  assign bus_req_o = valid_i && !cnt_full;

  // Phase is done once the bus takes it
  assign advance_o = bus_req_o && bus_gnt_i;

  // EX may move on only after the last phase
  assign ready_o = advance_o && !split_i;

  ////////////////////////////// Counter

  assign count_up   = advance_o;          // Transfer accepted
  assign count_down = bus_rvalid_i;       // Response seen, always for an accepted transfer

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;          // Idle, or grant and response together
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_next;
    end
  end

  ////////////////////////////// Status

  // Busy while anything waits for a grant or a response
  assign busy_o = valid_i || (cnt_q != '0);

endmodule

`default_nettype wire

//--- rtl/lsu_rdata_align.sv
// Write-back control queue, split low-half capture, read realignment, extension, wb valid
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       advance_i,     // Phase granted, control enters queue
  input  wire lsu_pkg::wb_ctrl_t          wb_ctrl_i,
  input  wire logic                       bus_rvalid_i,
  input  wire logic [lsu_pkg::DATA_W-1:0] bus_rdata_i,
  output logic      [lsu_pkg::DATA_W-1:0] rdata_o,       // Extended load data
  output logic                            wb_valid_o
);

  // One control entry per phase in flight, responses come back in order
  lsu_pkg::wb_ctrl_t          wb_mem [lsu_pkg::MAX_OUTSTANDING];
  logic [lsu_pkg::PTR_W-1:0]  wr_ptr_q;
  logic [lsu_pkg::PTR_W-1:0]  rd_ptr_q;
  lsu_pkg::wb_ctrl_t          wb_head;           // Control of the answered phase
  logic [lsu_pkg::DATA_W-1:0] rdata_q;           // First half of a split load
  logic                       rdata_is_split;
  logic [2*lsu_pkg::DATA_W-1:0] rdata_full;
  logic [2*lsu_pkg::DATA_W-1:0] rdata_shift;
  logic [lsu_pkg::DATA_W-1:0] rdata_aligned;

  always_ff @(posedge clk) begin
    if (advance_i) wb_mem[wr_ptr_q] <= wb_ctrl_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (advance_i)    wr_ptr_q <= wr_ptr_q + 1'b1;
      if (bus_rvalid_i) rd_ptr_q <= rd_ptr_q + 1'b1;   // Entry retires with its response
    end
  end

  assign wb_head = wb_mem[rd_ptr_q];

  // Keep the low word until the second half arrives
  always_ff @(posedge clk) begin
    if (bus_rvalid_i && !wb_head.we && !wb_head.last) rdata_q <= bus_rdata_i;
  end

  ////////////////////////////// Realignment
  assign rdata_is_split = ((wb_head.size == lsu_pkg::SIZE_WORD) && (wb_head.offset != 2'b00)) ||
                          ((wb_head.size == lsu_pkg::SIZE_HALF) && (wb_head.offset == 2'b11));

  assign rdata_full    = rdata_is_split ? {bus_rdata_i, rdata_q} : {bus_rdata_i, bus_rdata_i};
  assign rdata_shift   = rdata_full >> {wb_head.offset, 3'b000};
  assign rdata_aligned = rdata_shift[lsu_pkg::DATA_W-1:0];

  // Sign or zero extension by size
  always_comb begin
    case (wb_head.size)
      lsu_pkg::SIZE_BYTE: rdata_o = {{24{wb_head.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      lsu_pkg::SIZE_HALF: rdata_o = {{16{wb_head.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:            rdata_o = rdata_aligned;
    endcase
  end

  assign wb_valid_o = bus_rvalid_i && wb_head.last;   // Only the closing phase reports

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
// Load/store unit top level with request aligner, outstanding control and read aligner
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  // EX side
  input  wire logic                       valid_i,
  input  wire lsu_pkg::lsu_req_t          req_i,
  output logic                            ready_o,

  // Data bus
  output logic                            bus_req_o,
  output lsu_pkg::obi_req_t               bus_o,
  input  wire logic                       bus_gnt_i,
  input  wire logic                       bus_rvalid_i,
  input  wire logic [lsu_pkg::DATA_W-1:0] bus_rdata_i,

  // Write-back side, always ready
  output logic      [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                            wb_valid_o,
  output logic                            busy_o
);

  logic              split;           // First half of a split in EX
  logic              advance;         // Address phase accepted
  lsu_pkg::wb_ctrl_t wb_ctrl;

  ////////////////////////////// Request side
  lsu_req_align lsu_req_align_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (valid_i),
    .req_i     (req_i),
    .advance_i (advance),
    .bus_o     (bus_o),
    .split_o   (split),
    .wb_ctrl_o (wb_ctrl)
  );

  lsu_outstanding_ctrl lsu_outstanding_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .split_i      (split),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_req_o    (bus_req_o),
    .ready_o      (ready_o),
    .advance_o    (advance),
    .busy_o       (busy_o)
  );

  ////////////////////////////// Response side
  lsu_rdata_align lsu_rdata_align_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .advance_i    (advance),
    .wb_ctrl_i    (wb_ctrl),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .rdata_o      (rdata_o),
    .wb_valid_o   (wb_valid_o)
  );

endmodule

`default_nettype wire

//--- bench/lsu_mem_model.sv
// Data memory with random grant stalls and in-order delayed responses
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_model (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              bus_req_i,
  input  wire lsu_pkg::obi_req_t bus_i,
  output logic                   bus_gnt_o,
  output logic                   bus_rvalid_o,
  output logic [31:0]            bus_rdata_o
);

  localparam int WORDS = 64;                  // Covers byte addresses 0x00..0xFF

  logic [31:0] mem [WORDS];
  integer      seed;
  logic [1:0]  stall_q;                       // Cycles left before the next grant
  int unsigned cyc;
  int unsigned last_due;                      // Keeps responses ordered, one per cycle
  int unsigned due;
  int unsigned delay;
  logic [5:0]  idx;
  int unsigned due_q [$];
  logic [31:0] data_q [$];

  initial begin
    seed = 71193;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_0000;   // Fill depends on the whole index
    end
  end

  assign bus_gnt_o = bus_req_i && (stall_q == 2'd0);

  ////////////////////////////// Grant and response
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q      <= 2'd0;
      bus_rvalid_o <= 1'b0;
      bus_rdata_o  <= '0;
      cyc      = 0;
      last_due = 0;
      due_q.delete();
      data_q.delete();
    end else begin
      cyc = cyc + 1;
      if (bus_gnt_o) begin
        idx   = bus_i.addr[7:2];
        delay = 1 + ($unsigned($random(seed)) % 2);    // Visible 1 or 2 cycles later
        due   = cyc + delay - 1;
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        due_q.push_back(due);
        data_q.push_back(mem[idx]);
        if (bus_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (bus_i.be[b]) mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];  // Lane write
          end
        end
        stall_q <= 2'($unsigned($random(seed)) % 3);
      end else if (bus_req_i && (stall_q != 2'd0)) begin
        stall_q <= stall_q - 2'd1;
      end
      if ((due_q.size() > 0) && (due_q[0] == cyc)) begin
        bus_rvalid_o <= 1'b1;
        bus_rdata_o  <= data_q[0];
        void'(due_q.pop_front());
        void'(data_q.pop_front());
      end else begin
        bus_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
// Testbench for lsu_top with stimulus file, memory model, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int MAX_LINES = 64;

  logic              clk;
  logic              rst_n;
  logic              valid_i;
  lsu_pkg::lsu_req_t req_i;
  logic              ready_o;
  logic              bus_req_o;
  lsu_pkg::obi_req_t bus_o;
  logic              bus_gnt_i;
  logic              bus_rvalid_i;
  logic [31:0]       bus_rdata_i;
  logic [31:0]       rdata_o;
  logic              wb_valid_o;
  logic              busy_o;

  // Stimulus table
  logic [31:0] st_op [MAX_LINES];
  logic [31:0] st_size [MAX_LINES];
  logic [31:0] st_sext [MAX_LINES];
  logic [31:0] st_a [MAX_LINES];
  logic [31:0] st_b [MAX_LINES];
  logic [31:0] st_wdata [MAX_LINES];
  logic [31:0] st_exp [MAX_LINES];
  int          num_lines;

  bit          is_load_q [$];                 // One entry per access, in issue order
  logic [31:0] exp_q [$];
  int          outstanding;
  int          cycles;
  int          cycle_limit;

  lsu_top lsu_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .req_i        (req_i),
    .ready_o      (ready_o),
    .bus_req_o    (bus_req_o),
    .bus_o        (bus_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .rdata_o      (rdata_o),
    .wb_valid_o   (wb_valid_o),
    .busy_o       (busy_o)
  );

  lsu_mem_model mem_model_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req_o),
    .bus_i        (bus_o),
    .bus_gnt_o    (bus_gnt_i),
    .bus_rvalid_o (bus_rvalid_i),
    .bus_rdata_o  (bus_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////// Helpers
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Word off alignment or halfword at offset 3 takes two bus transfers
  function automatic bit needs_two_phases(input logic [31:0] a, input logic [31:0] b,
                                          input logic [31:0] size);
    logic [31:0] addr;
    addr = a + b;
    return ((size == 32'd2) && (addr[1:0] != 2'b00)) ||
           ((size == 32'd1) && (addr[1:0] == 2'b11));
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    fd = $fopen("bench/lsu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display("=== FAIL ===");
      $fatal(1, "Stimulus file missing");
    end
    num_lines = 0;
    while (!$feof(fd) && (num_lines < MAX_LINES)) begin
      line = "";
      void'($fgets(line, fd));
      if ((line.len() < 2) || (line.getc(0) == 8'h23)) continue;   // Blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h", st_op[num_lines], st_size[num_lines],
                  st_sext[num_lines], st_a[num_lines], st_b[num_lines],
                  st_wdata[num_lines], st_exp[num_lines]);
      if (n == 7) num_lines++;
    end
    $fclose(fd);
  endtask

  // Drive one access and hold it until ready, counting grants on the way
  task automatic run_access(input int i);
    int grants;
    int exp_grants;
    bit done;
    grants = 0;
    done = 0;
    exp_grants = needs_two_phases(st_a[i], st_b[i], st_size[i]) ? 2 : 1;
    valid_i         = 1'b1;
    req_i.operand_a = st_a[i];
    req_i.operand_b = st_b[i];
    req_i.wdata     = st_wdata[i];
    req_i.size      = lsu_pkg::lsu_size_e'(st_size[i][1:0]);
    req_i.sext      = st_sext[i][0];
    req_i.we        = st_op[i][0];
    while (!done) begin
      @(negedge clk);
      if (bus_req_o && bus_gnt_i) grants++;
      if (ready_o) begin
        done = 1;
        is_load_q.push_back(!st_op[i][0]);
        exp_q.push_back(st_exp[i]);
      end
      @(posedge clk);
      #1;
    end
    check_value("grant count", grants, exp_grants);
  endtask

  ////////////////////////////// Bus and write-back monitor
  // outstanding holds transfers accepted in earlier cycles and not yet answered
  always @(negedge clk) begin
    if (rst_n) begin
      if (bus_req_o && (outstanding >= lsu_pkg::MAX_OUTSTANDING)) begin
        $display("Bus request raised with %0d transfers outstanding at %0t ns",
                 outstanding, $time);
        $display("=== FAIL ===");
        $fatal(1, "Outstanding limit exceeded");
      end
      if (bus_req_o && bus_gnt_i) outstanding++;
      if (bus_rvalid_i) outstanding--;
      if (wb_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Write-back at %0t ns with no access waiting for it", $time);
          $display("=== FAIL ===");
          $fatal(1, "Unexpected write-back");
        end
        if (is_load_q[0]) check_value("rdata_o", rdata_o, exp_q[0]);
        void'(is_load_q.pop_front());
        void'(exp_q.pop_front());
      end
    end
  end

  // Run limit from the number of accesses
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles", cycles);
      $display("=== FAIL ===");
      $fatal(1, "Run did not finish");
    end
  end

  ////////////////////////////// Main sequence
  initial begin
    rst_n       = 1'b0;
    valid_i     = 1'b0;
    req_i       = '0;
    outstanding = 0;
    cycles      = 0;
    cycle_limit = 1000;
    load_stimulus();
    cycle_limit = 20 * num_lines + 50;

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("bus_req_o", {31'b0, bus_req_o}, 32'd0);     // Quiet in reset
    check_value("ready_o", {31'b0, ready_o}, 32'd0);
    check_value("wb_valid_o", {31'b0, wb_valid_o}, 32'd0);
    check_value("busy_o", {31'b0, busy_o}, 32'd0);
    @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < num_lines; i++) begin
      run_access(i);                          // Back to back, valid stays high
    end
    valid_i = 1'b0;

    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    check_value("busy_o", {31'b0, busy_o}, 32'd0);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/lsu_pkg.sv
rtl/lsu_req_align.sv
rtl/lsu_outstanding_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv

//--- Makefile
# Verilator lint and simulation of the load/store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
RTL_TOP   ?= lsu_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
SIMFLAGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) rtl/lsu_pkg.sv rtl/lsu_req_align.sv \
		rtl/lsu_outstanding_ctrl.sv rtl/lsu_rdata_align.sv rtl/lsu_top.sv \
		--top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/lsu_stimulus.txt
# op(1=store) size(0=B,1=H,2=W) sext operand_a operand_b store_data expected_load_data
# all fields hex
1 2 0 00000010 00000000 11223344 00000000
0 2 0 00000010 00000000 00000000 11223344
1 2 0 00000020 00000000 8899AABB 00000000
1 0 0 00000020 00000001 000000F0 00000000
1 1 0 00000020 00000002 00008001 00000000
0 0 1 00000020 00000000 00000000 FFFFFFBB
0 0 0 00000020 00000000 00000000 000000BB
0 0 1 00000020 00000001 00000000 FFFFFFF0
0 0 0 00000020 00000001 00000000 000000F0
0 0 1 00000020 00000002 00000000 00000001
0 0 0 00000020 00000003 00000000 00000080
0 0 1 00000020 00000003 00000000 FFFFFF80
0 1 1 00000020 00000000 00000000 FFFFF0BB
0 1 0 00000020 00000000 00000000 0000F0BB
0 1 1 00000020 00000001 00000000 000001F0
0 1 1 00000020 00000002 00000000 FFFF8001
0 1 0 00000020 00000002 00000000 00008001
0 2 0 00000020 00000000 00000000 8001F0BB
1 2 0 00000030 00000000 01020304 00000000
1 2 0 00000034 00000000 05060708 00000000
1 2 0 00000030 00000001 CAFEBABE 00000000
0 2 0 00000030 00000001 00000000 CAFEBABE
0 2 0 00000030 00000000 00000000 FEBABE04
0 2 0 00000034 00000000 00000000 050607CA
0 2 0 00000030 00000003 00000000 0607CAFE
0 2 0 00000030 00000002 00000000 07CAFEBA
1 2 0 00000038 00000000 11111111 00000000
1 2 0 0000003C 00000000 22222222 00000000
1 1 0 00000038 00000003 0000A55A 00000000
0 1 1 00000038 00000003 00000000 FFFFA55A
0 1 0 00000038 00000003 00000000 0000A55A
0 2 0 00000038 00000000 00000000 5A111111
0 2 0 0000003C 00000000 00000000 222222A5
0 2 0 00000010 00000000 00000000 11223344
0 2 0 00000020 00000000 00000000 8001F0BB
0 2 0 00000030 00000001 00000000 CAFEBABE
1 2 0 00000044 FFFFFFFC DEADBEEF 00000000
0 2 0 0000003C 00000004 00000000 DEADBEEF
